/* source/rename_pkg.sv */
// rename stage widths, vector types, queue line, renamed instruction and map structs
`default_nettype none

package rename_pkg;

   //////////////////////////////////////////////////
   // sizes
   //////////////////////////////////////////////////

   // queue depth and segment split, fixed at half
   localparam int ISQ_DEPTH = 8;
   localparam int SEG_DEPTH = ISQ_DEPTH / 2;
   localparam int NUM_LREGS = 8;
   localparam int LTAG_W    = 3;
   // 32 physical registers
   localparam int PTAG_W    = 5;
   // issue counter counts groups of two lines
   localparam int CNT_W     = 2;
   localparam int CTRL_W    = 8;
   // counter steps that cover one segment
   localparam int SEG_CNT   = SEG_DEPTH / 2;

   //////////////////////////////////////////////////
   // types
   //////////////////////////////////////////////////

   typedef logic [LTAG_W-1:0] ltag_t;
   typedef logic [PTAG_W-1:0] ptag_t;
   typedef logic [CNT_W-1:0]  cnt_t;

   // one map entry, ready bit above the tag
   typedef struct packed {
      logic  rdy;
      ptag_t ptag;
   } map_ent_t;

   // entry i belongs to logical register i
   typedef map_ent_t [NUM_LREGS-1:0] map_t;

   // queue line as it leaves the issue queue
   typedef struct packed {
      logic                wat;
      logic                vld;
      logic                src1_vld;
      ltag_t               lsrc1;
      logic                dst_vld;
      ltag_t               ldst;
      logic                src2_vld;
      ltag_t               lsrc2;
      logic [CTRL_W-1:0]   ctrl;
      ptag_t               pdest;
   } isq_line_t;

   // renamed instruction, ldst is dropped
   typedef struct packed {
      logic                wat;
      logic                vld;
      logic                src1_vld;
      ptag_t               psrc1;
      logic                psrc1_rdy;
      logic                src2_vld;
      ptag_t               psrc2;
      logic                psrc2_rdy;
      logic [CTRL_W-1:0]   ctrl;
      ptag_t               pdest;
   } ren_inst_t;

   // identity map, every entry ready
   localparam map_t RESET_MAP = {
      {1'b1, 5'd7}, {1'b1, 5'd6}, {1'b1, 5'd5}, {1'b1, 5'd4},
      {1'b1, 5'd3}, {1'b1, 5'd2}, {1'b1, 5'd1}, {1'b1, 5'd0}
   };

endpackage

`default_nettype wire

/* source/rename_line.sv */
// rename_line: source lookup, destination map update, freed tag, destination ready flag
`default_nettype none

module rename_line (
   input  wire                    clk,
   input  wire                    rst_n,
   input  rename_pkg::isq_line_t  isq_line_i,
   input  rename_pkg::map_t       prv_map_i,
   input  wire                    wb_en_i,
   input  wire                    wb_rdy_i,
   output rename_pkg::map_t       cur_map_o,
   output rename_pkg::ren_inst_t  ren_inst_o,
   output logic                   inst_rdy_o,
   output rename_pkg::ptag_t      free_ptag_o
);

   //////////////////////////////////////////////////
   // local signals
   //////////////////////////////////////////////////

   // ready flag of this line's destination
   logic                 dst_rdy_q;
   // map entries seen by the two sources
   rename_pkg::map_ent_t src1_ent;
   rename_pkg::map_ent_t src2_ent;
   // line writes a new mapping
   logic                 dst_wr;
   logic                 src1_rdy;
   logic                 src2_rdy;

   //////////////////////////////////////////////////
   // destination ready flag
   //////////////////////////////////////////////////

   // written by the writeback strobe, holds otherwise
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         dst_rdy_q <= 1'b0;
      end
      else if (wb_en_i)
      begin
         dst_rdy_q <= wb_rdy_i;
      end
   end

   //////////////////////////////////////////////////
   // source lookup
   //////////////////////////////////////////////////

   assign src1_ent = prv_map_i[isq_line_i.lsrc1];
   assign src2_ent = prv_map_i[isq_line_i.lsrc2];

   // an unused source shows tag 0 and not ready
   assign src1_rdy = isq_line_i.src1_vld & src1_ent.rdy;
   assign src2_rdy = isq_line_i.src2_vld & src2_ent.rdy;

   always_comb
   begin
      ren_inst_o.wat       = isq_line_i.wat;
      ren_inst_o.vld       = isq_line_i.vld;
      ren_inst_o.src1_vld  = isq_line_i.src1_vld;
      ren_inst_o.psrc1     = isq_line_i.src1_vld ? src1_ent.ptag : '0;
      ren_inst_o.psrc1_rdy = src1_rdy;
      ren_inst_o.src2_vld  = isq_line_i.src2_vld;
      ren_inst_o.psrc2     = isq_line_i.src2_vld ? src2_ent.ptag : '0;
      ren_inst_o.psrc2_rdy = src2_rdy;
      ren_inst_o.ctrl      = isq_line_i.ctrl;
      ren_inst_o.pdest     = isq_line_i.pdest;
   end

   // unused sources do not hold the line back
   assign inst_rdy_o = isq_line_i.vld
                     & (~isq_line_i.src1_vld | src1_rdy)
                     & (~isq_line_i.src2_vld | src2_rdy);

   //////////////////////////////////////////////////
   // map update and freed tag
   //////////////////////////////////////////////////

   assign dst_wr = isq_line_i.vld & isq_line_i.dst_vld;

   always_comb
   begin
      cur_map_o = prv_map_i;
      if (dst_wr)
      begin
         // new mapping carries this line's ready flag
         cur_map_o[isq_line_i.ldst].rdy  = dst_rdy_q;
         cur_map_o[isq_line_i.ldst].ptag = isq_line_i.pdest;
      end
   end

   // old mapping is released on a write, else own pdest goes back
   assign free_ptag_o = dst_wr ? prv_map_i[isq_line_i.ldst].ptag : isq_line_i.pdest;

endmodule

`default_nettype wire

/* source/seg_header_ctrl.sv */
// seg_header_ctrl: segment header maps, arch bit, switch condition, queue full flag
`default_nettype none

module seg_header_ctrl (
   input  wire                                             clk,
   input  wire                                             rst_n,
   input  rename_pkg::isq_line_t [rename_pkg::ISQ_DEPTH-1:0] isq_lines_i,
   input  rename_pkg::map_t                                mid_map_i,
   input  rename_pkg::map_t                                top_map_i,
   input  rename_pkg::cnt_t                                issue_cnt_i,
   output rename_pkg::map_t                                top_hdr_o,
   output rename_pkg::map_t                                mid_hdr_o,
   output logic                                            arch_o,
   output logic                                            isq_full_o
);

   //////////////////////////////////////////////////
   // local signals
   //////////////////////////////////////////////////

   rename_pkg::map_t               top_hdr_q;
   rename_pkg::map_t               mid_hdr_q;
   logic                           arch_q;
   // per line done, invalid or no longer waiting
   logic [rename_pkg::ISQ_DEPTH-1:0] line_done;
   logic                           low_seg_done;
   logic                           high_seg_done;
   // every entry at the segment boundary resolved
   logic                           mid_all_rdy;
   logic                           top_all_rdy;
   logic                           arch_swt;

   // and of all ready bits in a map
   function automatic logic map_all_rdy(rename_pkg::map_t m);
      logic r;
      r = 1'b1;
      for (int i = 0; i < rename_pkg::NUM_LREGS; i++)
      begin
         r &= m[i].rdy;
      end
      return r;
   endfunction

   //////////////////////////////////////////////////
   // switch condition
   //////////////////////////////////////////////////

   always_comb
   begin
      for (int i = 0; i < rename_pkg::ISQ_DEPTH; i++)
      begin
         line_done[i] = ~isq_lines_i[i].vld | ~isq_lines_i[i].wat;
      end
   end

   assign low_seg_done  = &line_done[rename_pkg::SEG_DEPTH-1:0];
   assign high_seg_done = &line_done[rename_pkg::ISQ_DEPTH-1:rename_pkg::SEG_DEPTH];

   assign mid_all_rdy = map_all_rdy(mid_map_i);
   assign top_all_rdy = map_all_rdy(top_map_i);

   // the oldest segment retires once it is done, resolved and behind the counter
   assign arch_swt = (!arch_q && (issue_cnt_i >= rename_pkg::CNT_W'(rename_pkg::SEG_CNT))
                      && low_seg_done && mid_all_rdy)
                   || (arch_q && (issue_cnt_i < rename_pkg::CNT_W'(rename_pkg::SEG_CNT))
                      && high_seg_done && top_all_rdy);

   //////////////////////////////////////////////////
   // headers and arch bit
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         top_hdr_q <= rename_pkg::RESET_MAP;
         mid_hdr_q <= rename_pkg::RESET_MAP;
         arch_q    <= 1'b0;
      end
      else if (arch_swt)
      begin
         // the retiring segment hands its final map to the next head
         if (arch_q)
         begin
            top_hdr_q <= top_map_i;
         end
         else
         begin
            mid_hdr_q <= mid_map_i;
         end
         arch_q <= ~arch_q;
      end
   end

   assign top_hdr_o = top_hdr_q;
   assign mid_hdr_o = mid_hdr_q;
   assign arch_o    = arch_q;

   // full at the last counter step of the youngest segment
   assign isq_full_o = (!arch_q && (issue_cnt_i == rename_pkg::CNT_W'(2 * rename_pkg::SEG_CNT - 1)))
                     || (arch_q && (issue_cnt_i == rename_pkg::CNT_W'(rename_pkg::SEG_CNT - 1)));

endmodule

`default_nettype wire

/* source/rename_unit.sv */
// rename_unit: rename line chain, segment head map routing, oldest first output rotation
`default_nettype none

module rename_unit (
   input  wire                                               clk,
   input  wire                                               rst_n,
   input  rename_pkg::isq_line_t [rename_pkg::ISQ_DEPTH-1:0] isq_lines_i,
   input  wire [rename_pkg::ISQ_DEPTH-1:0]                   wb_en_i,
   input  wire [rename_pkg::ISQ_DEPTH-1:0]                   wb_rdy_i,
   input  rename_pkg::cnt_t                                  issue_cnt_i,
   output rename_pkg::ren_inst_t [rename_pkg::ISQ_DEPTH-1:0] ren_insts_o,
   output logic [rename_pkg::ISQ_DEPTH-1:0]                  inst_rdy_o,
   output rename_pkg::ptag_t [rename_pkg::ISQ_DEPTH-1:0]     free_ptag_o,
   output logic                                              isq_full_o,
   output logic                                              arch_o
);

   //////////////////////////////////////////////////
   // local signals
   //////////////////////////////////////////////////

   // map into and out of each line, physical order
   rename_pkg::map_t      prv_map [rename_pkg::ISQ_DEPTH];
   rename_pkg::map_t      cur_map [rename_pkg::ISQ_DEPTH];
   // line results before rotation
   rename_pkg::ren_inst_t ren_raw [rename_pkg::ISQ_DEPTH];
   logic [rename_pkg::ISQ_DEPTH-1:0] rdy_raw;
   rename_pkg::ptag_t     free_raw [rename_pkg::ISQ_DEPTH];
   rename_pkg::map_t      top_hdr;
   rename_pkg::map_t      mid_hdr;
   logic                  arch;

   //////////////////////////////////////////////////
   // line chain
   //////////////////////////////////////////////////

   for (genvar k = 0; k < rename_pkg::ISQ_DEPTH; k++)
   begin : g_line
      // segment heads pick a header or wrap around
      if (k == 0)
      begin : g_top_head
         assign prv_map[k] = arch ? cur_map[rename_pkg::ISQ_DEPTH-1] : top_hdr;
      end
      else if (k == rename_pkg::SEG_DEPTH)
      begin : g_mid_head
         assign prv_map[k] = arch ? mid_hdr : cur_map[rename_pkg::SEG_DEPTH-1];
      end
      else
      begin : g_link
         assign prv_map[k] = cur_map[k-1];
      end

      rename_line i_rename_line (
         .clk         (clk),
         .rst_n       (rst_n),
         .isq_line_i  (isq_lines_i[k]),
         .prv_map_i   (prv_map[k]),
         .wb_en_i     (wb_en_i[k]),
         .wb_rdy_i    (wb_rdy_i[k]),
         .cur_map_o   (cur_map[k]),
         .ren_inst_o  (ren_raw[k]),
         .inst_rdy_o  (rdy_raw[k]),
         .free_ptag_o (free_raw[k])
      );
   end

   //////////////////////////////////////////////////
   // headers and arch state
   //////////////////////////////////////////////////

   seg_header_ctrl i_seg_header_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .isq_lines_i (isq_lines_i),
      .mid_map_i   (cur_map[rename_pkg::SEG_DEPTH-1]),
      .top_map_i   (cur_map[rename_pkg::ISQ_DEPTH-1]),
      .issue_cnt_i (issue_cnt_i),
      .top_hdr_o   (top_hdr),
      .mid_hdr_o   (mid_hdr),
      .arch_o      (arch),
      .isq_full_o  (isq_full_o)
   );

   assign arch_o = arch;

   //////////////////////////////////////////////////
   // output rotation
   //////////////////////////////////////////////////

   // with arch set the high segment is oldest, so swap halves
   for (genvar j = 0; j < rename_pkg::ISQ_DEPTH; j++)
   begin : g_rot
      localparam int ROT = (j + rename_pkg::SEG_DEPTH) % rename_pkg::ISQ_DEPTH;

      assign ren_insts_o[j] = arch ? ren_raw[ROT]  : ren_raw[j];
      assign inst_rdy_o[j]  = arch ? rdy_raw[ROT]  : rdy_raw[j];
      assign free_ptag_o[j] = arch ? free_raw[ROT] : free_raw[j];
   end

endmodule

`default_nettype wire

/* dv/clk_gen.sv */
// clk_gen: 100 ns testbench clock and active low reset held for 10 cycles
`default_nettype none

module clk_gen (
   output logic clk_o,
   output logic rst_n_o
);
   timeunit 1ns;
   timeprecision 1ps;

   initial
   begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;
   end

   // release on a falling edge, away from the capture edge
   initial
   begin
      rst_n_o = 1'b0;
      repeat (10) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

/* dv/rename_checker.sv */
// concurrent assertions on ready lines, arch switching and the full flag
`default_nettype none

module rename_checker (
   input wire                                                clk,
   input wire                                                rst_n,
   input rename_pkg::isq_line_t [rename_pkg::ISQ_DEPTH-1:0]  isq_lines_i,
   input rename_pkg::map_t                                   mid_map_i,
   input rename_pkg::map_t                                   top_map_i,
   input rename_pkg::cnt_t                                   issue_cnt_i,
   input wire [rename_pkg::ISQ_DEPTH-1:0]                    inst_rdy_i,
   input wire                                                arch_i,
   input wire                                                isq_full_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // input valid bit of the physical line shown on each output line
   logic [rename_pkg::ISQ_DEPTH-1:0] out_vld;
   logic [rename_pkg::ISQ_DEPTH-1:0] done;
   logic                             mid_rdy;
   logic                             top_rdy;
   logic                             swt;
   // number of failed assertions
   int                               fail_cnt = 0;

   always_comb
   begin
      mid_rdy = 1'b1;
      top_rdy = 1'b1;
      for (int i = 0; i < rename_pkg::ISQ_DEPTH; i++)
      begin
         // with arch set the high segment comes out first
         out_vld[i] = isq_lines_i[arch_i ? (i + 4) % 8 : i].vld;
         done[i]    = ~isq_lines_i[i].vld | ~isq_lines_i[i].wat;
      end
      for (int r = 0; r < rename_pkg::NUM_LREGS; r++)
      begin
         mid_rdy &= mid_map_i[r].rdy;
         top_rdy &= top_map_i[r].rdy;
      end
   end

   // independent copy of the segment retire condition
   assign swt = (!arch_i && issue_cnt_i >= 2'd2 && (&done[3:0]) && mid_rdy)
              || (arch_i && issue_cnt_i < 2'd2 && (&done[7:4]) && top_rdy);

   //////////////////////////////////////////////////
   // properties
   //////////////////////////////////////////////////

   a_rdy_needs_vld : assert property (@(posedge clk) disable iff (!rst_n)
      (inst_rdy_i & ~out_vld) == '0)
      else
      begin
         fail_cnt++;
         $error("inst_rdy set on an invalid output line");
      end

   a_arch_after_swt : assert property (@(posedge clk) disable iff (!rst_n)
      $changed(arch_i) |-> $past(swt))
      else
      begin
         fail_cnt++;
         $error("arch changed without a switch condition");
      end

   a_full_level : assert property (@(posedge clk) disable iff (!rst_n)
      isq_full_i == (arch_i ? (issue_cnt_i == 2'd1) : (issue_cnt_i == 2'd3)))
      else
      begin
         fail_cnt++;
         $error("isq_full does not match arch and counter");
      end

endmodule

`default_nettype wire

/* dv/tb_rename_unit.sv */
// testbench top with file driven stimulus, reference model of the rename chain and output checks
`default_nettype none

module tb_rename_unit;
   timeunit 1ns;
   timeprecision 1ps;

   logic                                                clk;
   logic                                                rst_n;
   rename_pkg::isq_line_t [rename_pkg::ISQ_DEPTH-1:0]   isq_lines;
   logic [rename_pkg::ISQ_DEPTH-1:0]                    wb_en;
   logic [rename_pkg::ISQ_DEPTH-1:0]                    wb_rdy;
   rename_pkg::cnt_t                                    issue_cnt;
   rename_pkg::ren_inst_t [rename_pkg::ISQ_DEPTH-1:0]   ren_insts;
   logic [rename_pkg::ISQ_DEPTH-1:0]                    inst_rdy;
   rename_pkg::ptag_t [rename_pkg::ISQ_DEPTH-1:0]       free_ptag;
   logic                                                isq_full;
   logic                                                arch;

   // model state that mirrors the registers of the stage
   rename_pkg::map_t      mdl_top;
   rename_pkg::map_t      mdl_mid;
   logic                  mdl_arch;
   logic [7:0]            mdl_dst_rdy;
   // expected line results in physical order
   rename_pkg::ren_inst_t exp_ren [8];
   rename_pkg::ptag_t     exp_free [8];
   rename_pkg::map_t      exp_map [8];
   logic [7:0]            exp_rdy;
   int                    errors;
   int                    checks;
   int                    vectors;

   clk_gen i_clk_gen (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   rename_unit i_rename_unit (
      .clk         (clk),
      .rst_n       (rst_n),
      .isq_lines_i (isq_lines),
      .wb_en_i     (wb_en),
      .wb_rdy_i    (wb_rdy),
      .issue_cnt_i (issue_cnt),
      .ren_insts_o (ren_insts),
      .inst_rdy_o  (inst_rdy),
      .free_ptag_o (free_ptag),
      .isq_full_o  (isq_full),
      .arch_o      (arch)
   );

   bind rename_unit rename_checker i_rename_checker (
      .clk         (clk),
      .rst_n       (rst_n),
      .isq_lines_i (isq_lines_i),
      .mid_map_i   (cur_map[rename_pkg::SEG_DEPTH-1]),
      .top_map_i   (cur_map[rename_pkg::ISQ_DEPTH-1]),
      .issue_cnt_i (issue_cnt_i),
      .inst_rdy_i  (inst_rdy_o),
      .arch_i      (arch_o),
      .isq_full_i  (isq_full_o)
   );

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   // token nibbles hold flags wat vld s1 s2, then dst+ldst, lsrc1, lsrc2, ctrl and pdest
   function automatic rename_pkg::isq_line_t decode_line(logic [31:0] t);
      rename_pkg::isq_line_t l;
      l.wat      = t[31];
      l.vld      = t[30];
      l.src1_vld = t[29];
      l.src2_vld = t[28];
      l.dst_vld  = t[27];
      l.ldst     = t[26:24];
      l.lsrc1    = t[22:20];
      l.lsrc2    = t[18:16];
      l.ctrl     = t[15:8];
      l.pdest    = t[4:0];
      return l;
   endfunction

   task automatic check_value(input string test, input string what,
                              input logic [63:0] exp_v, input logic [63:0] act_v);
      checks++;
      if (exp_v !== act_v)
      begin
         errors++;
         $display("Mismatch %s %s expected %h actual %h", test, what, exp_v, act_v);
      end
   endtask

   // walk the chain from the head of the oldest segment
   task automatic run_model();
      rename_pkg::map_t      m;
      rename_pkg::ren_inst_t ri;
      rename_pkg::isq_line_t l;
      int                    k;
      m = mdl_arch ? mdl_mid : mdl_top;
      for (int n = 0; n < 8; n++)
      begin
         k = mdl_arch ? (n + 4) % 8 : n;
         l = isq_lines[k];
         ri.wat       = l.wat;
         ri.vld       = l.vld;
         ri.src1_vld  = l.src1_vld;
         ri.psrc1     = l.src1_vld ? m[l.lsrc1].ptag : 5'd0;
         ri.psrc1_rdy = l.src1_vld & m[l.lsrc1].rdy;
         ri.src2_vld  = l.src2_vld;
         ri.psrc2     = l.src2_vld ? m[l.lsrc2].ptag : 5'd0;
         ri.psrc2_rdy = l.src2_vld & m[l.lsrc2].rdy;
         ri.ctrl      = l.ctrl;
         ri.pdest     = l.pdest;
         exp_ren[k]   = ri;
         exp_rdy[k]   = l.vld && (!l.src1_vld || ri.psrc1_rdy) && (!l.src2_vld || ri.psrc2_rdy);
         if (l.vld && l.dst_vld)
         begin
            exp_free[k]       = m[l.ldst].ptag;
            m[l.ldst].ptag    = l.pdest;
            m[l.ldst].rdy     = mdl_dst_rdy[k];
         end
         else
         begin
            exp_free[k] = l.pdest;
         end
         exp_map[k] = m;
      end
   endtask

   // segment lines done and its last map fully ready
   function automatic logic seg_retires(int base);
      logic ok;
      ok = 1'b1;
      for (int i = 0; i < 4; i++)
      begin
         if (isq_lines[base+i].vld && isq_lines[base+i].wat)
            ok = 1'b0;
      end
      for (int r = 0; r < 8; r++)
      begin
         if (!exp_map[base+3][r].rdy)
            ok = 1'b0;
      end
      return ok;
   endfunction

   task automatic compare_outputs(input string test);
      int p;
      check_value(test, "arch", 64'(mdl_arch), 64'(arch));
      check_value(test, "isq_full",
                  64'(mdl_arch ? (issue_cnt == 2'd1) : (issue_cnt == 2'd3)), 64'(isq_full));
      for (int j = 0; j < 8; j++)
      begin
         p = mdl_arch ? (j + 4) % 8 : j;
         check_value(test, $sformatf("ren_inst[%0d]", j), 64'(exp_ren[p]), 64'(ren_insts[j]));
         check_value(test, $sformatf("inst_rdy[%0d]", j), 64'(exp_rdy[p]), 64'(inst_rdy[j]));
         check_value(test, $sformatf("free_ptag[%0d]", j), 64'(exp_free[p]), 64'(free_ptag[j]));
      end
   endtask

   // state update that the DUT performs at the coming rising edge
   task automatic step_state();
      if (!mdl_arch && issue_cnt >= 2'd2 && seg_retires(0))
      begin
         mdl_mid  = exp_map[3];
         mdl_arch = 1'b1;
      end
      else if (mdl_arch && issue_cnt < 2'd2 && seg_retires(4))
      begin
         mdl_top  = exp_map[7];
         mdl_arch = 1'b0;
      end
      mdl_dst_rdy = (mdl_dst_rdy & ~wb_en) | (wb_en & wb_rdy);
   endtask

   task automatic wait_reset_release(output logic ok);
      int cycles;
      cycles = 0;
      while (!rst_n && cycles < 40)
      begin
         @(negedge clk);
         cycles++;
      end
      ok = rst_n;
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial
   begin
      int          fd;
      int          n;
      int          asrt_fails;
      logic        ok;
      string       line;
      string       name;
      logic [31:0] cnt_v;
      logic [31:0] en_v;
      logic [31:0] rdy_v;
      logic [31:0] tok [8];
      isq_lines   = '0;
      wb_en       = '0;
      wb_rdy      = '0;
      issue_cnt   = '0;
      mdl_top     = rename_pkg::RESET_MAP;
      mdl_mid     = rename_pkg::RESET_MAP;
      mdl_arch    = 1'b0;
      mdl_dst_rdy = '0;
      errors      = 0;
      checks      = 0;
      vectors     = 0;
      asrt_fails  = 0;
      fd = $fopen("dv/rename_stimulus.txt", "r");
      wait_reset_release(ok);
      if (fd == 0 || !ok)
      begin
         $display("stimulus file missing or reset never released");
         $display("=== FAIL ===");
         $finish;
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 2 && line.substr(0, 1) != "//")
            begin
               n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name, cnt_v, en_v,
                           rdy_v, tok[0], tok[1], tok[2], tok[3], tok[4], tok[5], tok[6],
                           tok[7]);
               if (n != 12)
               begin
                  errors++;
                  $display("stimulus line could not be parsed: %s", line);
               end
               else
               begin
                  @(negedge clk);
                  for (int i = 0; i < 8; i++)
                     isq_lines[i] = decode_line(tok[i]);
                  wb_en     = en_v[7:0];
                  wb_rdy    = rdy_v[7:0];
                  issue_cnt = cnt_v[1:0];
                  #20;
                  run_model();
                  compare_outputs(name);
                  step_state();
                  vectors++;
               end
            end
         end
         $fclose(fd);
         // the checker samples the last vector at the next rising edge
         @(negedge clk);
         asrt_fails = i_rename_unit.i_rename_checker.fail_cnt;
         if (vectors == 0)
         begin
            errors++;
            $display("no stimulus vectors were applied");
         end
         $display("vectors %0d checks %0d errors %0d assertion failures %0d",
                  vectors, checks, errors, asrt_fails);
         if (errors == 0 && asrt_fails == 0)
            $display("=== PASS ===");
         else
            $display("=== FAIL ===");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* verilog.f */
source/rename_pkg.sv
source/rename_line.sv
source/seg_header_ctrl.sv
source/rename_unit.sv
dv/clk_gen.sv
dv/rename_checker.sv
dv/tb_rename_unit.sv

/* Makefile */
# Verilator build and run for the rename stage

VERILATOR ?= verilator
TOP       ?= tb_rename_unit
RTL_TOP   ?= rename_unit
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* dv/rename_stimulus.txt */
// columns: test cnt wb_en wb_rdy line0 .. line7 (hex)
// line token nibbles: {wat vld s1 s2} {dst ldst} lsrc1 lsrc2 ctrl(2) pdest(2)
reset_map    0 00 00 F012011A C0000001 E0700002 D0060003 E0400004 00000005 C0000006 00000007
reset_map    0 00 00 F012011A C0000001 E0700002 D0060003 E0400004 00000005 C0000006 00000007
pass_thru    0 00 00 0B121120 C0000021 E0300022 00000023 0C000024 E0400025 4A000026 C0000027
dep_chain    0 00 00 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
dep_chain    0 00 00 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
wb_line0     0 01 01 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
wb_seen0     0 00 00 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
wb_line1     0 02 02 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
wb_seen1     0 00 00 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
wb_clear7    1 80 00 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
wb_line7     1 80 80 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
full_arch0   3 00 00 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
full_arch0   3 00 00 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
hold_wait    2 00 00 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
switch_arch0 2 00 00 7B121108 7D342209 60503314 00000015 E0300416 C0000017 00000018 C9000019
rotated      2 00 00 7B121108 7D342209 60503314 00000015 E0300416 C0000017 00000018 C9000019
rotated      3 00 00 7B121108 7D342209 60503314 00000015 E0300416 C0000017 00000018 C9000019
full_arch1   1 00 00 7B121108 7D342209 60503314 00000015 E0300416 C0000017 00000018 C9000019
full_arch1   1 00 00 7B121108 7D342209 60503314 00000015 E0300416 C0000017 00000018 C9000019
mid_head     2 00 00 7B121108 7D342209 60503314 00000015 60300416 40000017 00000018 49000019
switch_arch1 0 00 00 7B121108 7D342209 60503314 00000015 60300416 40000017 00000018 49000019
back_arch0   0 00 00 7B121108 7D342209 60503314 00000015 60300416 40000017 00000018 49000019
back_arch0   0 00 00 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
wb_low_clr   1 03 00 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
wb_low_seen  1 00 00 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
full_again   3 00 00 FB121108 FD342209 E0503314 00000015 E0300416 C0000017 00000018 C9000019
